// ==== src.f ====
+incdir+include
src/rob_pkg.sv
src/rob_buffer.sv
src/arch_state.sv
src/writeback_commit.sv
tests/tb_clock.sv
tests/writeback_commit_checker.sv
tests/writeback_commit_tb.sv

// ==== Makefile ====
# Verilator build and run for the writeback and commit testbench

VERILATOR ?= verilator
TOP       ?= writeback_commit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/writeback_commit_tb.sv ====
// Top testbench for the writeback and commit path
// Stimulus, LCG, in-order scoreboard, register mirror, watchdog

`timescale 1ns/1ns
`include "rob_settings.svh"

module writeback_commit_tb;

  localparam int TOTAL_OPS = 58;

  logic clk, arst_n, alloc_en, alloc_rdy, wb_en, commit_en, commit_valid;
  rob_pkg::arch_reg_t   alloc_dest, rd_addr;
  rob_pkg::rob_tag_t    alloc_tag;
  rob_pkg::wb_msg_t     wb_msg;
  rob_pkg::commit_msg_t commit_msg, exp_msg;
  rob_pkg::rob_data_t   rd_data;

  // Model of allocations in order, results by tag and the register file
  rob_pkg::commit_msg_t exp_q [$];
  rob_pkg::rob_data_t   wb_data [rob_pkg::ROB_ENTRIES];
  rob_pkg::rob_data_t   mirror [rob_pkg::ARCH_REG_COUNT];
  rob_pkg::rob_tag_t    tags [4];
  int commits = 0, errors = 0, tests_run = 0, tests_failed = 0;
  logic [31:0] seed = 32'he402;

  tb_clock u_clock (.clk(clk), .arst_n(arst_n));

  writeback_commit DUT (.*);

  bind writeback_commit writeback_commit_checker u_checker (
    .clk(clk), .arst_n(arst_n), .alloc_en(alloc_en), .alloc_rdy(alloc_rdy),
    .alloc_tag(alloc_tag), .commit_en(commit_en), .commit_valid(commit_valid),
    .commit_msg(commit_msg)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // Testbench errors plus failed checker assertions
  function automatic int error_count();
    return errors + int'(DUT.u_checker.failures);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Scoreboard comparing each announcement with the oldest allocation
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    if (arst_n && commit_valid) begin
      if (exp_q.size() == 0) begin
        check_true(1'b0, "commit announced with nothing in flight");
      end else begin
        exp_msg = exp_q.pop_front();
        exp_msg.data = wb_data[exp_msg.tag];
        check_value("commit_msg.tag", 32'(commit_msg.tag), 32'(exp_msg.tag));
        check_value("commit_msg.dest", 32'(commit_msg.dest), 32'(exp_msg.dest));
        check_value("commit_msg.data", commit_msg.data, exp_msg.data);
        mirror[exp_msg.dest] = exp_msg.data;
      end
      commits++;
    end
  end

  // ------------------------------------------------------------------------
  // Drivers entered and left on a falling edge
  // ------------------------------------------------------------------------
  task automatic alloc_one(input rob_pkg::arch_reg_t dest, output rob_pkg::rob_tag_t tag);
    rob_pkg::commit_msg_t e;
    check_true(alloc_rdy, "allocation attempted while ROB full");
    alloc_en = 1'b1;
    alloc_dest = dest;
    tag = alloc_tag;
    e = '{tag: alloc_tag, dest: dest, data: '0};
    exp_q.push_back(e);
    @(negedge clk);
    alloc_en = 1'b0;
  endtask

  task automatic write_back(input rob_pkg::rob_tag_t tag, input rob_pkg::rob_data_t data);
    wb_en = 1'b1;
    wb_msg = '{tag: tag, data: data};
    wb_data[tag] = data;
    @(negedge clk);
    wb_en = 1'b0;
  endtask

  task automatic wait_commits(input int target);
    while (commits < target) @(negedge clk);
  endtask

  // Address held for a full cycle, read back on the next falling edge
  task automatic check_reg(input rob_pkg::arch_reg_t addr);
    rd_addr = addr;
    @(negedge clk);
    check_value($sformatf("rd_data[%0d]", addr), rd_data, mirror[addr]);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (error_count() > errs_before) tests_failed++;
    $display("%-12s %s", name, (error_count() > errs_before) ? "failed" : "ok");
  endtask

  // Fill the ROB with consecutive destinations starting at base
  task automatic fill_rob(input int base);
    for (int i = 0; i < 4; i++) alloc_one(rob_pkg::arch_reg_t'(base + i), tags[i]);
  endtask

  // ------------------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------------------
  initial begin
    #(TOTAL_OPS * `ROB_DEPTH * 4 * 4);
    $display("Watchdog expired at %0t ns, run did not finish", $time);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------
  initial begin
    int e0, start, allocated, idx;
    logic [31:0] r;
    logic got_alloc;
    rob_pkg::rob_tag_t new_tag, stale_tag;
    rob_pkg::rob_tag_t pend [$];

    alloc_en = 0;
    alloc_dest = '0;
    wb_en = 0;
    wb_msg = '0;
    commit_en = 0;
    rd_addr = '0;
    for (int i = 0; i < rob_pkg::ARCH_REG_COUNT; i++) mirror[i] = '0;
    @(posedge arst_n);
    @(negedge clk);

    // Basic flow of one instruction end to end
    e0 = error_count();
    commit_en = 1'b1;
    alloc_one(4'd5, tags[0]);
    write_back(tags[0], lcg_next());
    wait_commits(1);
    check_reg(4'd5);
    end_test("basic", e0);

    // Full ROB ignores an extra allocation
    e0 = error_count();
    commit_en = 1'b0;
    fill_rob(0);
    check_true(!alloc_rdy, "alloc_rdy high with ROB full");
    stale_tag = alloc_tag;
    alloc_en = 1'b1;
    @(negedge clk);
    alloc_en = 1'b0;
    check_value("alloc_tag", 32'(alloc_tag), 32'(stale_tag));
    write_back(tags[0], lcg_next());
    commit_en = 1'b1;
    wait_commits(2);
    check_true(alloc_rdy, "alloc_rdy still low after head retired");
    for (int i = 1; i < 4; i++) write_back(tags[i], lcg_next());
    wait_commits(5);
    end_test("capacity", e0);

    // Out-of-order results in program positions 3, 1, 2 and 0
    e0 = error_count();
    fill_rob(8);
    write_back(tags[3], lcg_next());
    write_back(tags[1], lcg_next());
    write_back(tags[2], lcg_next());
    repeat (2) @(negedge clk);
    check_true(commits == 5, "commit seen before the oldest result");
    write_back(tags[0], lcg_next());
    wait_commits(9);
    for (int i = 8; i < 12; i++) check_reg(rob_pkg::arch_reg_t'(i));
    end_test("out_of_order", e0);

    // Commit held off with every result present
    e0 = error_count();
    commit_en = 1'b0;
    fill_rob(12);
    for (int i = 0; i < 4; i++) write_back(tags[i], lcg_next());
    repeat (3) @(negedge clk);
    check_true(commits == 9, "commit seen while commit_en low");
    commit_en = 1'b1;
    wait_commits(13);
    for (int i = 12; i < 16; i++) check_reg(rob_pkg::arch_reg_t'(i));
    end_test("stall", e0);

    // Random stream with allocation, writeback and commit overlapping
    e0 = error_count();
    start = commits;
    allocated = 0;
    while (allocated < 40 || pend.size() > 0) begin
      got_alloc = 1'b0;
      r = lcg_next();
      if (allocated < 40 && alloc_rdy && r[16]) begin
        alloc_en = 1'b1;
        alloc_dest = rob_pkg::arch_reg_t'(r[27:24]);
        new_tag = alloc_tag;
        exp_q.push_back(rob_pkg::commit_msg_t'{tag: alloc_tag, dest: alloc_dest, data: '0});
        got_alloc = 1'b1;
        allocated++;
      end
      if (pend.size() > 0 && r[20]) begin
        idx = int'(lcg_next() % pend.size());
        wb_en = 1'b1;
        wb_msg = '{tag: pend[idx], data: lcg_next()};
        wb_data[pend[idx]] = wb_msg.data;
        pend.delete(idx);
      end
      @(negedge clk);
      alloc_en = 1'b0;
      wb_en = 1'b0;
      if (got_alloc) pend.push_back(new_tag);
    end
    wait_commits(start + 40);
    for (int i = 0; i < rob_pkg::ARCH_REG_COUNT; i++) check_reg(rob_pkg::arch_reg_t'(i));
    end_test("random", e0);

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count());
    if (error_count() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/writeback_commit_checker.sv ====
// Concurrent assertions on the writeback and commit top-level ports
// Commit timing, tag ordering, reset values

`timescale 1ns/1ns

module writeback_commit_checker (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 alloc_en,
  input logic                 alloc_rdy,
  input rob_pkg::rob_tag_t    alloc_tag,
  input logic                 commit_en,
  input logic                 commit_valid,
  input rob_pkg::commit_msg_t commit_msg
);

  // Last retired tag for ordering across gaps between commits
  rob_pkg::rob_tag_t last_tag_q;
  logic              seen_q;

  // Failed assertions so far
  int unsigned failures = 0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_tag_q <= '0;
      seen_q     <= 1'b0;
    end else if (commit_valid) begin
      last_tag_q <= commit_msg.tag;
      seen_q     <= 1'b1;
    end
  end

  // Announcement only follows a cycle with commit allowed
  commit_after_enable: assert property (@(posedge clk) disable iff (!arst_n)
    commit_valid |-> $past(commit_en))
    else begin
      $error("commit_valid without commit_en in the previous cycle");
      failures++;
    end

  // Tail steps by one and wraps with the pointer width
  alloc_tag_steps: assert property (@(posedge clk) disable iff (!arst_n)
    (alloc_en && alloc_rdy) |=> (alloc_tag == rob_pkg::rob_tag_t'($past(alloc_tag) + 1'b1)))
    else begin
      $error("alloc_tag did not advance after an accepted allocation");
      failures++;
    end

  // Retirement in program order
  commit_tag_steps: assert property (@(posedge clk) disable iff (!arst_n)
    (commit_valid && seen_q) |-> (commit_msg.tag == rob_pkg::rob_tag_t'(last_tag_q + 1'b1)))
    else begin
      $error("committed tag out of order");
      failures++;
    end

  // Idle levels right after reset release
  reset_levels: assert property (@(posedge clk)
    $rose(arst_n) |-> (alloc_rdy && !commit_valid))
    else begin
      $error("wrong alloc_rdy or commit_valid after reset");
      failures++;
    end

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset source
// 4 ns clock, reset held low for 3 cycles

`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// ==== src/writeback_commit.sv ====
// Writeback and commit top level
// ROB feeding the architectural state

`timescale 1ns/1ns

module writeback_commit (
  input  logic                 clk,
  input  logic                 arst_n,

  // Dispatch side
  input  logic                 alloc_en,
  input  rob_pkg::arch_reg_t   alloc_dest,
  output logic                 alloc_rdy,
  output rob_pkg::rob_tag_t    alloc_tag,

  // Execution results
  input  logic                 wb_en,
  input  rob_pkg::wb_msg_t     wb_msg,

  // Retirement control and announcement
  input  logic                 commit_en,
  output logic                 commit_valid,
  output rob_pkg::commit_msg_t commit_msg,

  // Register read port
  input  rob_pkg::arch_reg_t   rd_addr,
  output rob_pkg::rob_data_t   rd_data
);

  // ROB head toward the architectural state
  logic                 deq_en;
  logic                 deq_rdy;
  rob_pkg::commit_msg_t deq_msg;

  // -------------------------------------------------------------------------
  // Reorder buffer
  // -------------------------------------------------------------------------

  rob_buffer u_rob (
    .clk        (clk),
    .arst_n     (arst_n),
    .alloc_en   (alloc_en),
    .alloc_dest (alloc_dest),
    .alloc_rdy  (alloc_rdy),
    .alloc_tag  (alloc_tag),
    .wb_en      (wb_en),
    .wb_msg     (wb_msg),
    .deq_en     (deq_en),
    .deq_rdy    (deq_rdy),
    .deq_msg    (deq_msg)
  );

  // -------------------------------------------------------------------------
  // Architectural state
  // -------------------------------------------------------------------------

  arch_state u_arch (
    .clk          (clk),
    .arst_n       (arst_n),
    .commit_en    (commit_en),
    .deq_rdy      (deq_rdy),
    .deq_msg      (deq_msg),
    .deq_en       (deq_en),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .commit_valid (commit_valid),
    .commit_msg   (commit_msg)
  );

endmodule

// ==== src/arch_state.sv ====
// Architectural state
// Commit control, register file with one read port, commit announcement

`timescale 1ns/1ns

module arch_state (
  input  logic                 clk,
  input  logic                 arst_n,

  // External permission to retire
  input  logic                 commit_en,

  // Head of the ROB
  input  logic                 deq_rdy,
  input  rob_pkg::commit_msg_t deq_msg,
  output logic                 deq_en,

  // Read port for outside consumers
  input  rob_pkg::arch_reg_t   rd_addr,
  output rob_pkg::rob_data_t   rd_data,

  // One-cycle retirement announcement
  output logic                 commit_valid,
  output rob_pkg::commit_msg_t commit_msg
);

  // -------------------------------------------------------------------------
  // Retirement decision
  // -------------------------------------------------------------------------

  // Head retires when its result is present and commit is allowed
  assign deq_en = deq_rdy && commit_en;

  // -------------------------------------------------------------------------
  // Register file
  // -------------------------------------------------------------------------

  rob_pkg::rob_data_t regs_q [rob_pkg::ARCH_REG_COUNT];

  // Architectural values start at zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rob_pkg::ARCH_REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (deq_en) begin
      regs_q[deq_msg.dest] <= deq_msg.data;
    end
  end

  // Combinational read, new value seen the cycle after commit
  assign rd_data = regs_q[rd_addr];

  // -------------------------------------------------------------------------
  // Commit announcement
  // -------------------------------------------------------------------------

  // Valid pulses for exactly the cycle after each commit edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= deq_en;
    end
  end

  // Message held until the next retirement
  always_ff @(posedge clk) begin
    if (deq_en) begin
      commit_msg <= deq_msg;
    end
  end

endmodule

// ==== src/rob_buffer.sv ====
// Reorder buffer
// In-order tag allocation, indexed writeback insert, in-order head dequeue

`timescale 1ns/1ns

module rob_buffer (
  input  logic                 clk,
  input  logic                 arst_n,

  // Allocation from dispatch
  input  logic                 alloc_en,
  input  rob_pkg::arch_reg_t   alloc_dest,
  output logic                 alloc_rdy,
  output rob_pkg::rob_tag_t    alloc_tag,

  // Writeback from execution units
  input  logic                 wb_en,
  input  rob_pkg::wb_msg_t     wb_msg,

  // Head dequeue toward commit
  input  logic                 deq_en,
  output logic                 deq_rdy,
  output rob_pkg::commit_msg_t deq_msg
);

  // -------------------------------------------------------------------------
  // Storage and pointers
  // -------------------------------------------------------------------------

  // Entry lifecycle, cleared on reset
  rob_pkg::rob_state_e state_q [rob_pkg::ROB_ENTRIES];

  // Payload per entry, written on allocate and writeback
  rob_pkg::arch_reg_t dest_q [rob_pkg::ROB_ENTRIES];
  rob_pkg::rob_data_t data_q [rob_pkg::ROB_ENTRIES];

  // Oldest entry and next free slot
  rob_pkg::rob_tag_t head_q;
  rob_pkg::rob_tag_t tail_q;

  // Occupancy, decides full and empty
  logic [rob_pkg::ROB_CNT_BITS-1:0] count_q;

  logic full;
  logic empty;
  logic alloc_fire;
  logic deq_fire;

  // -------------------------------------------------------------------------
  // Status and handshake levels
  // -------------------------------------------------------------------------

  assign full  = (count_q == rob_pkg::ROB_CNT_BITS'(rob_pkg::ROB_ENTRIES));
  assign empty = (count_q == '0);

  // Dispatch may allocate whenever a slot is free
  assign alloc_rdy = !full;
  assign alloc_tag = tail_q;

  // Head can retire only once its result has arrived
  assign deq_rdy = !empty && (state_q[head_q] == rob_pkg::ENTRY_DONE);

  // Head entry presented as a commit message
  assign deq_msg.tag  = head_q;
  assign deq_msg.dest = dest_q[head_q];
  assign deq_msg.data = data_q[head_q];

  // Accepted transfers this cycle
  assign alloc_fire = alloc_en && alloc_rdy;
  assign deq_fire   = deq_en && deq_rdy;

  // -------------------------------------------------------------------------
  // Entry state
  // -------------------------------------------------------------------------

  // Head, tail and writeback slots never coincide in a legal cycle:
  // head is DONE, writeback targets ISSUED, tail is FREE
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < rob_pkg::ROB_ENTRIES; i++) begin
        state_q[i] <= rob_pkg::ENTRY_FREE;
      end
    end else begin
      for (int i = 0; i < rob_pkg::ROB_ENTRIES; i++) begin
        if (deq_fire && (head_q == rob_pkg::rob_tag_t'(i))) begin
          // Retired, slot returns to the pool
          state_q[i] <= rob_pkg::ENTRY_FREE;
        end else if (wb_en && (wb_msg.tag == rob_pkg::rob_tag_t'(i))) begin
          // Result arrived out of order
          state_q[i] <= rob_pkg::ENTRY_DONE;
        end else if (alloc_fire && (tail_q == rob_pkg::rob_tag_t'(i))) begin
          state_q[i] <= rob_pkg::ENTRY_ISSUED;
        end
      end
    end
  end

  // -------------------------------------------------------------------------
  // Payload
  // -------------------------------------------------------------------------

  // Destination captured at dispatch
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      dest_q[tail_q] <= alloc_dest;
    end
  end

  // Result captured at its own tag
  always_ff @(posedge clk) begin
    if (wb_en) begin
      data_q[wb_msg.tag] <= wb_msg.data;
    end
  end

  // -------------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------------

  // Pointer width equals log2 depth, so increment wraps by itself
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_q <= '0;
      tail_q <= '0;
    end else begin
      if (alloc_fire) begin
        tail_q <= tail_q + 1'b1;
      end
      if (deq_fire) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  // Simultaneous allocate and retire leaves the count unchanged
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else begin
      case ({alloc_fire, deq_fire})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/rob_pkg.sv ====
// Shared types for the writeback and commit path
// Tag, register and data types, entry state, message structs

`include "rob_settings.svh"

package rob_pkg;

  // -------------------------------------------------------------------------
  // Derived sizes
  // -------------------------------------------------------------------------

  // Entry count and index width
  localparam int ROB_ENTRIES = `ROB_DEPTH;
  localparam int ROB_TAG_BITS = $clog2(`ROB_DEPTH);

  // Occupancy counter must reach ROB_ENTRIES itself
  localparam int ROB_CNT_BITS = $clog2(`ROB_DEPTH + 1);

  // Register file size and index width
  localparam int ARCH_REG_COUNT = `ROB_ARCH_REGS;
  localparam int ARCH_REG_BITS = $clog2(`ROB_ARCH_REGS);

  // -------------------------------------------------------------------------
  // Scalar types
  // -------------------------------------------------------------------------

  typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;
  typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;
  typedef logic [`ROB_DATA_BITS-1:0] rob_data_t;

  // Per-entry lifecycle
  typedef enum logic [1:0] {
    ENTRY_FREE,
    ENTRY_ISSUED,
    ENTRY_DONE
  } rob_state_e;

  // -------------------------------------------------------------------------
  // Messages
  // -------------------------------------------------------------------------

  // Result from an execution unit, addressed by tag
  typedef struct packed {
    rob_tag_t  tag;
    rob_data_t data;
  } wb_msg_t;

  // Retiring instruction, head of ROB and commit announcement
  typedef struct packed {
    rob_tag_t  tag;
    arch_reg_t dest;
    rob_data_t data;
  } commit_msg_t;

endpackage

// ==== include/rob_settings.svh ====
// Build-time sizing for the reorder buffer and architectural state
// Depth, result width and register count

`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Reorder buffer sizing
// ---------------------------------------------------------------------------

// Entries in flight, must be a power of two
`define ROB_DEPTH 4

// Result word width
`define ROB_DATA_BITS 32

// Architectural registers visible to commit
`define ROB_ARCH_REGS 16

`endif
